// File: hw/mrd_num_pkg.sv
package mrd_num_pkg;

	// Datapath widths
	localparam int SAMPLE_W = 18;
	localparam int EXP_W    = 4;
	localparam int MARGIN_W = 2;

	// Complex lanes per vector
	localparam int LANES = 5;

	// Lane component, 1.17 two's complement
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Shared block exponent
	typedef logic [EXP_W-1:0] exp_t;

	// Guard bits known to be free
	typedef logic [MARGIN_W-1:0] margin_t;

	// Largest margin the stage reports
	localparam margin_t MARGIN_MAX = 2'd3;

endpackage

// File: hw/mrd_ctrl_pkg.sv
package mrd_ctrl_pkg;

	// Butterfly selected for a block
	typedef enum logic {
		RADIX2 = 1'b0,
		RADIX3 = 1'b1
	} radix_e;

	// Block controller states
	typedef enum logic {
		IDLE = 1'b0,
		RUN  = 1'b1
	} ctrl_state_e;

	// Cycles from butterfly input valid to output valid
	localparam int BFLY_LAT = 4;

endpackage

// File: hw/mrd_lane_if.sv
`timescale 1ns/1ps

interface mrd_lane_if;

	logic                 val;
	mrd_num_pkg::sample_t re [mrd_num_pkg::LANES];
	mrd_num_pkg::sample_t im [mrd_num_pkg::LANES];
	mrd_num_pkg::exp_t    exp;
	mrd_num_pkg::margin_t margin;

	modport src (
		output val,
		output re,
		output im,
		output exp,
		output margin
	);

	modport dst (
		input val,
		input re,
		input im,
		input exp,
		input margin
	);

endinterface

// File: hw/mrd_block_ctrl.sv
`timescale 1ns/1ps

module mrd_block_ctrl #(
	parameter int BLOCK_LEN = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_val_i,
	input  logic                 sob_i,
	input  mrd_ctrl_pkg::radix_e radix_i,
	input  mrd_num_pkg::margin_t margin_i,
	input  mrd_num_pkg::exp_t    exp_i,
	input  mrd_num_pkg::sample_t din_re_i [mrd_num_pkg::LANES],
	input  mrd_num_pkg::sample_t din_im_i [mrd_num_pkg::LANES],
	mrd_lane_if.src              bf2_o,
	mrd_lane_if.src              bf3_o,
	output logic                 last_o
);

	localparam int CNT_W = $clog2(BLOCK_LEN + 1);

	mrd_ctrl_pkg::ctrl_state_e state_q;
	logic [CNT_W-1:0]          cnt_q;
	mrd_ctrl_pkg::radix_e      radix_q;
	mrd_ctrl_pkg::radix_e      radix_sel;
	mrd_num_pkg::margin_t      margin_q;
	mrd_num_pkg::exp_t         exp_q;
	logic                      start;
	logic                      accept;
	logic                      blk_end;
	logic                      bf2_val_q;
	logic                      bf3_val_q;
	logic                      last_q;
	logic [mrd_ctrl_pkg::BFLY_LAT-1:0] last_sr;
	mrd_num_pkg::sample_t      re_q [mrd_num_pkg::LANES];
	mrd_num_pkg::sample_t      im_q [mrd_num_pkg::LANES];
	mrd_num_pkg::exp_t         exp_out_q;
	mrd_num_pkg::margin_t      margin_out_q;

	// A start of block counts only while idle
	assign start   = in_val_i && sob_i && (state_q == mrd_ctrl_pkg::IDLE);
	assign accept  = start || (in_val_i && (state_q == mrd_ctrl_pkg::RUN));
	assign blk_end = accept && (cnt_q == CNT_W'(BLOCK_LEN - 1));

	// First vector of a block takes the parameters straight from the ports
	assign radix_sel = start ? radix_i : radix_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q   <= mrd_ctrl_pkg::IDLE;
			cnt_q     <= '0;
			bf2_val_q <= 1'b0;
			bf3_val_q <= 1'b0;
			last_q    <= 1'b0;
			last_sr   <= '0;
		end else begin
			bf2_val_q <= accept && (radix_sel == mrd_ctrl_pkg::RADIX2);
			bf3_val_q <= accept && (radix_sel == mrd_ctrl_pkg::RADIX3);
			last_q    <= blk_end;
			last_sr   <= {last_sr[mrd_ctrl_pkg::BFLY_LAT-2:0], last_q};
			if (blk_end) begin
				state_q <= mrd_ctrl_pkg::IDLE;
				cnt_q   <= '0;
			end else if (accept) begin
				state_q <= mrd_ctrl_pkg::RUN;
				cnt_q   <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			radix_q  <= radix_i;
			margin_q <= margin_i;
			exp_q    <= exp_i;
		end
		if (accept) begin
			re_q         <= din_re_i;
			im_q         <= din_im_i;
			exp_out_q    <= start ? exp_i : exp_q;
			margin_out_q <= start ? margin_i : margin_q;
		end
	end

	// Payload is shared, only the valid picks the butterfly
	assign bf2_o.val    = bf2_val_q;
	assign bf2_o.re     = re_q;
	assign bf2_o.im     = im_q;
	assign bf2_o.exp    = exp_out_q;
	assign bf2_o.margin = margin_out_q;

	assign bf3_o.val    = bf3_val_q;
	assign bf3_o.re     = re_q;
	assign bf3_o.im     = im_q;
	assign bf3_o.exp    = exp_out_q;
	assign bf3_o.margin = margin_out_q;

	assign last_o = last_sr[mrd_ctrl_pkg::BFLY_LAT-1];

endmodule

// File: hw/mrd_rdx2.sv
`timescale 1ns/1ps

module mrd_rdx2 (
	input  logic    clk,
	input  logic    rst_n,
	mrd_lane_if.dst in_i,
	mrd_lane_if.src out_o
);

	logic [mrd_ctrl_pkg::BFLY_LAT-1:0] val_sr;
	mrd_num_pkg::margin_t growth;

	// Stage 1, sum and difference at 2.17
	logic signed [18:0]   s1_re [2];
	logic signed [18:0]   s1_im [2];
	mrd_num_pkg::margin_t g1;
	mrd_num_pkg::exp_t    e1;
	// Stage 2, scaled with one extra fraction bit
	logic signed [19:0]   s2_re [2];
	logic signed [19:0]   s2_im [2];
	mrd_num_pkg::exp_t    e2;
	// Stage 3, rounded back to 1.17
	mrd_num_pkg::sample_t s3_re [2];
	mrd_num_pkg::sample_t s3_im [2];
	mrd_num_pkg::exp_t    e3;
	// Stage 4
	mrd_num_pkg::sample_t out_re_q [mrd_num_pkg::LANES];
	mrd_num_pkg::sample_t out_im_q [mrd_num_pkg::LANES];
	mrd_num_pkg::exp_t    out_exp_q;

	// One bit of worst case growth unless the margin already covers it
	assign growth = (in_i.margin == 2'd0) ? 2'd1 : 2'd0;

	always_ff @(posedge clk) begin
		if (!rst_n)
			val_sr <= '0;
		else
			val_sr <= {val_sr[mrd_ctrl_pkg::BFLY_LAT-2:0], in_i.val};
	end

	always_ff @(posedge clk) begin
		s1_re[0] <= in_i.re[0] + in_i.re[1];
		s1_im[0] <= in_i.im[0] + in_i.im[1];
		s1_re[1] <= in_i.re[0] - in_i.re[1];
		s1_im[1] <= in_i.im[0] - in_i.im[1];
		g1       <= growth;
		e1       <= in_i.exp + growth;

		for (int k = 0; k < 2; k++) begin
			s2_re[k] <= $signed({s1_re[k], 1'b0}) >>> g1;
			s2_im[k] <= $signed({s1_im[k], 1'b0}) >>> g1;
			// Round half up on the extra bit
			s3_re[k] <= s2_re[k][18:1] + {17'd0, s2_re[k][0]};
			s3_im[k] <= s2_im[k][18:1] + {17'd0, s2_im[k][0]};
			out_re_q[k] <= s3_re[k];
			out_im_q[k] <= s3_im[k];
		end
		e2 <= e1;
		e3 <= e2;

		for (int k = 2; k < mrd_num_pkg::LANES; k++) begin
			out_re_q[k] <= '0;
			out_im_q[k] <= '0;
		end
		out_exp_q <= e3;
	end

	assign out_o.val    = val_sr[mrd_ctrl_pkg::BFLY_LAT-1];
	assign out_o.re     = out_re_q;
	assign out_o.im     = out_im_q;
	assign out_o.exp    = out_exp_q;
	assign out_o.margin = '0;

endmodule

// File: hw/mrd_rdx3.sv
`timescale 1ns/1ps

module mrd_rdx3 (
	input  logic    clk,
	input  logic    rst_n,
	mrd_lane_if.dst in_i,
	mrd_lane_if.src out_o
);

	// sin(60 deg) in 1.17
	localparam logic signed [17:0] SIN60 = 18'sh1BB68;

	logic [mrd_ctrl_pkg::BFLY_LAT-1:0] val_sr;
	mrd_num_pkg::margin_t growth;

	// Stage 1
	logic signed [19:0]   dif_re;
	logic signed [19:0]   dif_im;
	mrd_num_pkg::sample_t s1_x0_re;
	mrd_num_pkg::sample_t s1_x0_im;
	logic signed [18:0]   s1_sum_re;
	logic signed [18:0]   s1_sum_im;
	logic signed [18:0]   s1_hd_re;
	logic signed [18:0]   s1_hd_im;
	mrd_num_pkg::margin_t g1;
	mrd_num_pkg::exp_t    e1;

	// Stage 2
	logic signed [36:0]   prod_re;
	logic signed [36:0]   prod_im;
	logic signed [19:0]   s2_y0_re;
	logic signed [19:0]   s2_y0_im;
	logic signed [20:0]   s2_m_re;
	logic signed [20:0]   s2_m_im;
	logic signed [23:0]   s2_rot_re;
	logic signed [23:0]   s2_rot_im;
	mrd_num_pkg::margin_t g2;
	mrd_num_pkg::exp_t    e2;

	// Stage 3, all terms at 4.20
	logic signed [23:0]   m_al_re;
	logic signed [23:0]   m_al_im;
	logic signed [23:0]   s3_v_re [3];
	logic signed [23:0]   s3_v_im [3];
	mrd_num_pkg::margin_t g3;
	mrd_num_pkg::exp_t    e3;

	// Stage 4
	logic signed [23:0]   sh_re [3];
	logic signed [23:0]   sh_im [3];
	mrd_num_pkg::sample_t out_re_q [mrd_num_pkg::LANES];
	mrd_num_pkg::sample_t out_im_q [mrd_num_pkg::LANES];
	mrd_num_pkg::exp_t    out_exp_q;

	// Up to two bits of growth, less whatever margin is already free
	assign growth = (in_i.margin >= 2'd2) ? 2'd0 : 2'd2 - in_i.margin;

	always_ff @(posedge clk) begin
		if (!rst_n)
			val_sr <= '0;
		else
			val_sr <= {val_sr[mrd_ctrl_pkg::BFLY_LAT-2:0], in_i.val};
	end

	// Halved difference, rounded half up
	assign dif_re = in_i.re[2] - in_i.re[1] + 20'sd1;
	assign dif_im = in_i.im[2] - in_i.im[1] + 20'sd1;

	always_ff @(posedge clk) begin
		s1_x0_re  <= in_i.re[0];
		s1_x0_im  <= in_i.im[0];
		s1_sum_re <= in_i.re[1] + in_i.re[2];
		s1_sum_im <= in_i.im[1] + in_i.im[2];
		s1_hd_re  <= dif_re[19:1];
		s1_hd_im  <= dif_im[19:1];
		g1        <= growth;
		e1        <= in_i.exp + growth;
	end

	// j * sin60 * (x2 - x1)
	assign prod_re = -(s1_hd_im * SIN60);
	assign prod_im = s1_hd_re * SIN60;

	always_ff @(posedge clk) begin
		s2_y0_re  <= s1_x0_re + s1_sum_re;
		s2_y0_im  <= s1_x0_im + s1_sum_im;
		// x0 - (x1 + x2)/2 kept exact at 2^-18
		s2_m_re   <= $signed({s1_x0_re, 1'b0}) - s1_sum_re;
		s2_m_im   <= $signed({s1_x0_im, 1'b0}) - s1_sum_im;
		s2_rot_re <= prod_re[36:13];
		s2_rot_im <= prod_im[36:13];
		g2        <= g1;
		e2        <= e1;
	end

	assign m_al_re = {s2_m_re[20], s2_m_re, 2'b00};
	assign m_al_im = {s2_m_im[20], s2_m_im, 2'b00};

	always_ff @(posedge clk) begin
		s3_v_re[0] <= {s2_y0_re[19], s2_y0_re, 3'b000};
		s3_v_im[0] <= {s2_y0_im[19], s2_y0_im, 3'b000};
		s3_v_re[1] <= m_al_re + s2_rot_re;
		s3_v_im[1] <= m_al_im + s2_rot_im;
		s3_v_re[2] <= m_al_re - s2_rot_re;
		s3_v_im[2] <= m_al_im - s2_rot_im;
		g3         <= g2;
		e3         <= e2;
	end

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			sh_re[k] = s3_v_re[k] >>> g3;
			sh_im[k] = s3_v_im[k] >>> g3;
		end
	end

	always_ff @(posedge clk) begin
		// Bit 2 is half an output LSB
		for (int k = 0; k < 3; k++) begin
			out_re_q[k] <= sh_re[k][20:3] + {17'd0, sh_re[k][2]};
			out_im_q[k] <= sh_im[k][20:3] + {17'd0, sh_im[k][2]};
		end
		for (int k = 3; k < mrd_num_pkg::LANES; k++) begin
			out_re_q[k] <= '0;
			out_im_q[k] <= '0;
		end
		out_exp_q <= e3;
	end

	assign out_o.val    = val_sr[mrd_ctrl_pkg::BFLY_LAT-1];
	assign out_o.re     = out_re_q;
	assign out_o.im     = out_im_q;
	assign out_o.exp    = out_exp_q;
	assign out_o.margin = '0;

endmodule

// File: hw/mrd_stage_merge.sv
`timescale 1ns/1ps

module mrd_stage_merge (
	input  logic                 clk,
	input  logic                 rst_n,
	mrd_lane_if.dst              bf2_i,
	mrd_lane_if.dst              bf3_i,
	input  logic                 last_i,
	output logic                 out_val_o,
	output mrd_num_pkg::sample_t dout_re_o [mrd_num_pkg::LANES],
	output mrd_num_pkg::sample_t dout_im_o [mrd_num_pkg::LANES],
	output mrd_num_pkg::exp_t    exp_o,
	output mrd_num_pkg::margin_t blk_margin_o,
	output logic                 blk_margin_val_o
);

	mrd_num_pkg::margin_t vec_min;
	mrd_num_pkg::margin_t run_min_q;
	mrd_num_pkg::margin_t blk_min;

	// Redundant sign bits below the sign, saturated
	function automatic mrd_num_pkg::margin_t rsb(input mrd_num_pkg::sample_t x);
		mrd_num_pkg::margin_t n;
		logic                 same;
		n    = '0;
		same = 1'b1;
		for (int b = 1; b <= int'(mrd_num_pkg::MARGIN_MAX); b++) begin
			same = same && (x[mrd_num_pkg::SAMPLE_W-1-b] == x[mrd_num_pkg::SAMPLE_W-1]);
			if (same)
				n = mrd_num_pkg::margin_t'(b);
		end
		return n;
	endfunction

	assign out_val_o = bf2_i.val || bf3_i.val;

	always_comb begin
		vec_min = mrd_num_pkg::MARGIN_MAX;
		for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
			dout_re_o[k] = bf3_i.val ? bf3_i.re[k] : bf2_i.re[k];
			dout_im_o[k] = bf3_i.val ? bf3_i.im[k] : bf2_i.im[k];
			if (rsb(dout_re_o[k]) < vec_min)
				vec_min = rsb(dout_re_o[k]);
			if (rsb(dout_im_o[k]) < vec_min)
				vec_min = rsb(dout_im_o[k]);
		end
	end

	assign blk_min = (run_min_q < vec_min) ? run_min_q : vec_min;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exp_o            <= '0;
			run_min_q        <= mrd_num_pkg::MARGIN_MAX;
			blk_margin_o     <= '0;
			blk_margin_val_o <= 1'b0;
		end else begin
			blk_margin_val_o <= out_val_o && last_i;
			if (out_val_o) begin
				exp_o <= bf3_i.val ? bf3_i.exp : bf2_i.exp;
				// Last vector closes the block and restarts the minimum
				if (last_i) begin
					blk_margin_o <= blk_min;
					run_min_q    <= mrd_num_pkg::MARGIN_MAX;
				end else begin
					run_min_q <= blk_min;
				end
			end
		end
	end

endmodule

// File: hw/mrd_stage_top.sv
`timescale 1ns/1ps

module mrd_stage_top #(
	parameter int BLOCK_LEN = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_val_i,
	input  logic                 sob_i,
	input  mrd_ctrl_pkg::radix_e radix_i,
	input  mrd_num_pkg::margin_t margin_i,
	input  mrd_num_pkg::exp_t    exp_i,
	input  mrd_num_pkg::sample_t din_re_i [mrd_num_pkg::LANES],
	input  mrd_num_pkg::sample_t din_im_i [mrd_num_pkg::LANES],
	output logic                 out_val_o,
	output mrd_num_pkg::sample_t dout_re_o [mrd_num_pkg::LANES],
	output mrd_num_pkg::sample_t dout_im_o [mrd_num_pkg::LANES],
	output mrd_num_pkg::exp_t    exp_o,
	output mrd_num_pkg::margin_t blk_margin_o,
	output logic                 blk_margin_val_o
);

	logic last;

	mrd_lane_if bf2_in ();
	mrd_lane_if bf3_in ();
	mrd_lane_if bf2_out ();
	mrd_lane_if bf3_out ();

	mrd_block_ctrl #(
		.BLOCK_LEN (BLOCK_LEN)
	) u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_val_i (in_val_i),
		.sob_i    (sob_i),
		.radix_i  (radix_i),
		.margin_i (margin_i),
		.exp_i    (exp_i),
		.din_re_i (din_re_i),
		.din_im_i (din_im_i),
		.bf2_o    (bf2_in),
		.bf3_o    (bf3_in),
		.last_o   (last)
	);

	mrd_rdx2 u_rdx2 (
		.clk   (clk),
		.rst_n (rst_n),
		.in_i  (bf2_in),
		.out_o (bf2_out)
	);

	mrd_rdx3 u_rdx3 (
		.clk   (clk),
		.rst_n (rst_n),
		.in_i  (bf3_in),
		.out_o (bf3_out)
	);

	mrd_stage_merge u_merge (
		.clk              (clk),
		.rst_n            (rst_n),
		.bf2_i            (bf2_out),
		.bf3_i            (bf3_out),
		.last_i           (last),
		.out_val_o        (out_val_o),
		.dout_re_o        (dout_re_o),
		.dout_im_o        (dout_im_o),
		.exp_o            (exp_o),
		.blk_margin_o     (blk_margin_o),
		.blk_margin_val_o (blk_margin_val_o)
	);

endmodule

// File: sim/tb_mrd_tasks.svh
`ifndef TB_MRD_TASKS_SVH
`define TB_MRD_TASKS_SVH

// Round half up after dropping the low bits and wrap to 18 bits
function automatic mrd_num_pkg::sample_t rnd_half_up(input longint v, input int drop);
	longint r;
	r = (v + (longint'(1) <<< (drop - 1))) >>> drop;
	return mrd_num_pkg::sample_t'(r);
endfunction

// Bits below the sign that repeat it, up to a cap of 3
function automatic mrd_num_pkg::margin_t count_sign_bits(input mrd_num_pkg::sample_t x);
	int n;
	int b;
	n = 0;
	b = mrd_num_pkg::SAMPLE_W - 2;
	while (b >= 0 && n < 3 && x[b] == x[mrd_num_pkg::SAMPLE_W-1]) begin
		n++;
		b--;
	end
	return mrd_num_pkg::margin_t'(n);
endfunction

task automatic model_vec(input mrd_ctrl_pkg::radix_e r, input mrd_num_pkg::margin_t m,
		input vec_t xr, input vec_t xi, output vec_t yr, output vec_t yi,
		output mrd_num_pkg::exp_t g);
	longint sr, si;
	longint hr, hi;
	longint y0r, y0i;
	longint m2r, m2i;
	longint rotr, roti;
	longint vr, vi;
	yr = '0;
	yi = '0;
	if (r == mrd_ctrl_pkg::RADIX2) begin
		g = (m == 0) ? 4'd1 : 4'd0;
		for (int k = 0; k < 2; k++) begin
			if (k == 0) begin
				vr = longint'(xr[0]) + longint'(xr[1]);
				vi = longint'(xi[0]) + longint'(xi[1]);
			end else begin
				vr = longint'(xr[0]) - longint'(xr[1]);
				vi = longint'(xi[0]) - longint'(xi[1]);
			end
			yr[k] = rnd_half_up((vr * 2) >>> g, 1);
			yi[k] = rnd_half_up((vi * 2) >>> g, 1);
		end
	end else begin
		g = (m >= 2) ? 4'd0 : 4'(2 - m);
		sr = longint'(xr[1]) + longint'(xr[2]);
		si = longint'(xi[1]) + longint'(xi[2]);
		hr = (longint'(xr[2]) - longint'(xr[1]) + 1) >>> 1;
		hi = (longint'(xi[2]) - longint'(xi[1]) + 1) >>> 1;
		y0r = longint'(xr[0]) + sr;
		y0i = longint'(xi[0]) + si;
		// Half LSB units for x0 - (x1 + x2)/2
		m2r = 2 * longint'(xr[0]) - sr;
		m2i = 2 * longint'(xi[0]) - si;
		rotr = (-(hi * SIN60)) >>> 13;
		roti = (hr * SIN60) >>> 13;
		yr[0] = rnd_half_up((y0r * 8) >>> g, 3);
		yi[0] = rnd_half_up((y0i * 8) >>> g, 3);
		yr[1] = rnd_half_up((m2r * 4 + rotr) >>> g, 3);
		yi[1] = rnd_half_up((m2i * 4 + roti) >>> g, 3);
		yr[2] = rnd_half_up((m2r * 4 - rotr) >>> g, 3);
		yi[2] = rnd_half_up((m2i * 4 - roti) >>> g, 3);
	end
endtask

task automatic cmp_sample(input string name, input mrd_num_pkg::sample_t got,
		input mrd_num_pkg::sample_t want);
	if (got !== want) begin
		$display("Mismatch %s: got %h expected %h", name, got, want);
		err_data++;
	end
endtask

task automatic cmp_exp(input string name, input mrd_num_pkg::exp_t got,
		input mrd_num_pkg::exp_t want);
	if (got !== want) begin
		$display("Mismatch %s: got %h expected %h", name, got, want);
		err_exp++;
	end
endtask

task automatic cmp_margin(input string name, input mrd_num_pkg::margin_t got,
		input mrd_num_pkg::margin_t want);
	if (got !== want) begin
		$display("Mismatch %s: got %h expected %h", name, got, want);
		err_margin++;
	end
endtask

task automatic rand_vec(input int sh, output vec_t re, output vec_t im);
	mrd_num_pkg::sample_t s;
	for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
		s = mrd_num_pkg::sample_t'(rand_bits(18));
		re[k] = s >>> sh;
		s = mrd_num_pkg::sample_t'(rand_bits(18));
		im[k] = s >>> sh;
	end
endtask

// Drives one accepted vector and books the expected results
task automatic send_vec(input bit sob, input mrd_ctrl_pkg::radix_e r,
		input mrd_num_pkg::margin_t m, input mrd_num_pkg::exp_t e,
		input vec_t re, input vec_t im);
	expect_t ev;
	mexp_t   me;
	mrd_num_pkg::exp_t g;
	@(negedge clk);
	in_val   = 1'b1;
	sob_in   = sob;
	radix    = r;
	margin   = m;
	exp_in   = e;
	for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
		din_re[k] = re[k];
		din_im[k] = im[k];
	end
	if (!in_block) begin
		in_block  = 1'b1;
		blk_radix = r;
		blk_marg  = m;
		blk_exp   = e;
		blk_cnt   = 0;
		blk_min   = 2'd3;
	end
	model_vec(blk_radix, blk_marg, re, im, ev.re, ev.im, g);
	ev.e = blk_exp + g;
	ev.t = $time;
	exp_q.push_back(ev);
	for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
		if (count_sign_bits(ev.re[k]) < blk_min)
			blk_min = count_sign_bits(ev.re[k]);
		if (count_sign_bits(ev.im[k]) < blk_min)
			blk_min = count_sign_bits(ev.im[k]);
	end
	n_acc++;
	blk_cnt++;
	if (blk_cnt == BLOCK_LEN) begin
		me.m = blk_min;
		me.t = $time + 60;
		marg_q.push_back(me);
		in_block = 1'b0;
	end
endtask

task automatic send_gap();
	@(negedge clk);
	in_val = 1'b0;
	sob_in = (rand_bits(1) != 0);
	for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
		din_re[k] = mrd_num_pkg::sample_t'(rand_bits(18));
		din_im[k] = mrd_num_pkg::sample_t'(rand_bits(18));
	end
endtask

task automatic drain();
	int n;
	n = 0;
	@(negedge clk);
	in_val = 1'b0;
	sob_in = 1'b0;
	while ((exp_q.size() != 0 || marg_q.size() != 0) && n < 100) begin
		@(negedge clk);
		n++;
	end
	if (n >= 100) begin
		$display("Timeout: outputs did not drain, %0d vectors and %0d margins left",
			exp_q.size(), marg_q.size());
		err_other++;
		exp_q.delete();
		marg_q.delete();
	end
	repeat (2) @(negedge clk);
endtask

task automatic run_block(input mrd_ctrl_pkg::radix_e r, input mrd_num_pkg::margin_t m,
		input mrd_num_pkg::exp_t e, input int sh, input bit gaps, input bit stray);
	vec_t re;
	vec_t im;
	mrd_ctrl_pkg::radix_e other_radix;
	other_radix = (r == mrd_ctrl_pkg::RADIX2) ? mrd_ctrl_pkg::RADIX3 : mrd_ctrl_pkg::RADIX2;
	for (int i = 0; i < BLOCK_LEN; i++) begin
		while (gaps && rand_bits(2) == 0)
			send_gap();
		rand_vec(sh, re, im);
		if (stray && i == 3)
			send_vec(1'b1, other_radix, 2'd0, 4'd9, re, im);
		else
			send_vec(i == 0, r, m, e, re, im);
	end
endtask

task automatic test_rdx3_margin2();
	run_block(mrd_ctrl_pkg::RADIX3, 2'd2, 4'd5, 2, 1'b0, 1'b0);
	drain();
endtask

task automatic test_rdx3_low_margin();
	run_block(mrd_ctrl_pkg::RADIX3, 2'd0, 4'd3, 0, 1'b0, 1'b0);
	run_block(mrd_ctrl_pkg::RADIX3, 2'd1, 4'd14, 1, 1'b0, 1'b0);
	drain();
endtask

task automatic test_rdx2_random();
	run_block(mrd_ctrl_pkg::RADIX2, 2'd0, 4'd7, 0, 1'b0, 1'b0);
	run_block(mrd_ctrl_pkg::RADIX2, 2'd1, 4'd2, 1, 1'b0, 1'b0);
	drain();
endtask

task automatic test_back_to_back();
	for (int b = 0; b < 4; b++)
		run_block(b[0] ? mrd_ctrl_pkg::RADIX2 : mrd_ctrl_pkg::RADIX3,
			mrd_num_pkg::margin_t'(b), 4'(b + 1), b, 1'b0, 1'b1);
	drain();
endtask

task automatic test_block_margin();
	run_block(mrd_ctrl_pkg::RADIX3, 2'd0, 4'd1, 0, 1'b0, 1'b0);
	run_block(mrd_ctrl_pkg::RADIX2, 2'd2, 4'd1, 9, 1'b0, 1'b0);
	run_block(mrd_ctrl_pkg::RADIX3, 2'd2, 4'd1, 5, 1'b0, 1'b0);
	drain();
endtask

task automatic test_gaps();
	int acc0;
	int out0;
	acc0 = n_acc;
	out0 = n_out;
	run_block(mrd_ctrl_pkg::RADIX3, 2'd1, 4'd4, 1, 1'b1, 1'b0);
	run_block(mrd_ctrl_pkg::RADIX2, 2'd1, 4'd6, 1, 1'b1, 1'b0);
	drain();
	if (n_out - out0 != n_acc - acc0) begin
		$display("Output count wrong: %0d valid outputs for %0d accepted vectors",
			n_out - out0, n_acc - acc0);
		err_other++;
	end
endtask

`endif

// File: sim/tb_mrd_stage.sv
`timescale 1ns/1ps

module tb_mrd_stage;

	localparam int BLOCK_LEN = 8;
	// sin(60 deg) in 1.17
	localparam longint SIN60 = 113512;

	typedef mrd_num_pkg::sample_t [mrd_num_pkg::LANES-1:0] vec_t;

	typedef struct packed {
		vec_t              re;
		vec_t              im;
		mrd_num_pkg::exp_t e;
		logic [63:0]       t;
	} expect_t;

	typedef struct packed {
		mrd_num_pkg::margin_t m;
		logic [63:0]          t;
	} mexp_t;

	logic                 clk;
	logic                 rst_n;
	logic                 in_val;
	logic                 sob_in;
	mrd_ctrl_pkg::radix_e radix;
	mrd_num_pkg::margin_t margin;
	mrd_num_pkg::exp_t    exp_in;
	mrd_num_pkg::sample_t din_re [mrd_num_pkg::LANES];
	mrd_num_pkg::sample_t din_im [mrd_num_pkg::LANES];
	logic                 out_val;
	mrd_num_pkg::sample_t dout_re [mrd_num_pkg::LANES];
	mrd_num_pkg::sample_t dout_im [mrd_num_pkg::LANES];
	mrd_num_pkg::exp_t    exp_out;
	mrd_num_pkg::margin_t blk_margin;
	logic                 blk_margin_val;

	expect_t exp_q [$];
	mexp_t   marg_q [$];
	logic [31:0] lfsr_q;

	// Model state of the block in progress
	bit                   in_block;
	mrd_ctrl_pkg::radix_e blk_radix;
	mrd_num_pkg::margin_t blk_marg;
	mrd_num_pkg::exp_t    blk_exp;
	mrd_num_pkg::margin_t blk_min;
	int                   blk_cnt;

	int n_acc;
	int n_out;
	int err_data;
	int err_exp;
	int err_margin;
	int err_other;
	bit                exp_pend;
	mrd_num_pkg::exp_t exp_pend_val;

	mrd_stage_top #(
		.BLOCK_LEN (BLOCK_LEN)
	) uut (
		.clk              (clk),
		.rst_n            (rst_n),
		.in_val_i         (in_val),
		.sob_i            (sob_in),
		.radix_i          (radix),
		.margin_i         (margin),
		.exp_i            (exp_in),
		.din_re_i         (din_re),
		.din_im_i         (din_im),
		.out_val_o        (out_val),
		.dout_re_o        (dout_re),
		.dout_im_o        (dout_im),
		.exp_o            (exp_out),
		.blk_margin_o     (blk_margin),
		.blk_margin_val_o (blk_margin_val)
	);

	// Taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r      = {r[30:0], fb};
		end
		return r;
	endfunction

	`include "tb_mrd_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Outputs change on rising edges and are checked on falling ones
	always @(negedge clk) begin
		expect_t ev;
		mexp_t   me;
		if (rst_n) begin
			if (exp_pend)
				cmp_exp("exp_o", exp_out, exp_pend_val);
			exp_pend = 1'b0;
			if (out_val === 1'b1) begin
				n_out++;
				if (exp_q.size() == 0) begin
					$display("Output valid seen with no vector in flight");
					err_other++;
				end else begin
					ev = exp_q.pop_front();
					if ($time != ev.t + 50) begin
						$display("Output arrived at %0t, expected at %0t", $time, ev.t + 50);
						err_other++;
					end
					for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
						cmp_sample($sformatf("dout_re_o[%0d]", k), dout_re[k], ev.re[k]);
						cmp_sample($sformatf("dout_im_o[%0d]", k), dout_im[k], ev.im[k]);
					end
					exp_pend     = 1'b1;
					exp_pend_val = ev.e;
				end
			end
			if (blk_margin_val === 1'b1) begin
				if (marg_q.size() == 0) begin
					$display("Block margin strobe seen with no block finished");
					err_other++;
				end else begin
					me = marg_q.pop_front();
					if ($time != me.t) begin
						$display("Block margin strobe at %0t, expected at %0t", $time, me.t);
						err_other++;
					end
					cmp_margin("blk_margin_o", blk_margin, me.m);
				end
			end
		end
	end

	initial begin
		lfsr_q   = 32'd94652;
		rst_n    = 1'b0;
		in_val   = 1'b0;
		sob_in   = 1'b0;
		radix    = mrd_ctrl_pkg::RADIX2;
		margin   = '0;
		exp_in   = '0;
		for (int k = 0; k < mrd_num_pkg::LANES; k++) begin
			din_re[k] = '0;
			din_im[k] = '0;
		end
		in_block   = 1'b0;
		blk_cnt    = 0;
		n_acc      = 0;
		n_out      = 0;
		err_data   = 0;
		err_exp    = 0;
		err_margin = 0;
		err_other  = 0;
		exp_pend   = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (out_val !== 1'b0 || blk_margin_val !== 1'b0 || exp_out !== '0) begin
			$display("Outputs not cleared after reset");
			err_other++;
		end

		test_rdx3_margin2();
		test_rdx3_low_margin();
		test_rdx2_random();
		test_back_to_back();
		test_block_margin();
		test_gaps();

		$display("Errors: data %0d, exponent %0d, margin %0d, other %0d",
			err_data, err_exp, err_margin, err_other);
		if (err_data + err_exp + err_margin + err_other == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: all.f
+incdir+sim
hw/mrd_num_pkg.sv
hw/mrd_ctrl_pkg.sv
hw/mrd_lane_if.sv
hw/mrd_block_ctrl.sv
hw/mrd_rdx2.sv
hw/mrd_rdx3.sv
hw/mrd_stage_merge.sv
hw/mrd_stage_top.sv
sim/tb_mrd_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_mrd_stage -o tb_mrd_stage
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/tb_mrd_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0
